//--- decoder_pkg.sv
package decoder_pkg;

    localparam int grid_x = 4; // rows, north to south
    localparam int grid_z = 3; // columns, west to east
    localparam int grid_u = 2; // measurement layers, bottom layer is 0

    localparam int x_bits = 2;
    localparam int z_bits = 2;
    localparam int u_bits = 1;
    localparam int addr_bits = u_bits + x_bits + z_bits;

    localparam int plane_count = grid_x * grid_z;
    localparam int vertex_count = plane_count * grid_u;

    localparam int growth_bits = 2;
    localparam logic [growth_bits-1:0] link_weight = 2'd2; // growth of a full edge

    // even ports look back along an axis, the next odd port is the opposite one
    localparam int neighbor_count = 6;
    localparam int dir_north = 0;
    localparam int dir_south = 1;
    localparam int dir_west = 2;
    localparam int dir_east = 3;
    localparam int dir_down = 4;
    localparam int dir_up = 5;

    typedef enum logic [2:0] {
        stage_idle = 3'd0,
        stage_load = 3'd1,
        stage_grow = 3'd2,
        stage_merge = 3'd3
    } stage_t;

    // field order makes the packed value sort like the linear vertex index
    typedef struct packed {
        logic [u_bits-1:0] u;
        logic [x_bits-1:0] x;
        logic [z_bits-1:0] z;
    } vertex_addr_t;

    typedef struct packed {
        vertex_addr_t root;
        logic boundary; // cluster touches the north or south edge
    } vertex_state_t;

    typedef struct packed {
        logic load;
        logic grow;
        logic merge;
    } stage_strobes_t;

    // address of vertex v, numbered u-major, then x, then z
    function automatic vertex_addr_t vertex_addr(int v);
        vertex_addr_t a;
        a.u = u_bits'(v / plane_count);
        a.x = x_bits'((v % plane_count) / grid_z);
        a.z = z_bits'(v % grid_z);
        return a;
    endfunction

    // linear index of the neighbour of v on port dir, -1 when off the lattice
    function automatic int neighbor_of(int v, int dir);
        int u;
        int x;
        int z;
        u = v / plane_count;
        x = (v % plane_count) / grid_z;
        z = v % grid_z;
        case (dir)
            dir_north: x = x - 1;
            dir_south: x = x + 1;
            dir_west: z = z - 1;
            dir_east: z = z + 1;
            dir_down: u = u - 1;
            default: u = u + 1;
        endcase
        if (u < 0 || u >= grid_u || x < 0 || x >= grid_x || z < 0 || z >= grid_z) begin
            return -1;
        end
        return u * plane_count + x * grid_z + z;
    endfunction

endpackage

//--- syndrome_loader.sv
`timescale 1ns/1ps

module syndrome_loader (
    input  logic clk,
    input  logic reset,
    input  decoder_pkg::stage_t stage_i,
    input  logic [decoder_pkg::plane_count-1:0] measurements_i,
    output decoder_pkg::stage_strobes_t strobes_o,
    output logic [decoder_pkg::vertex_count-1:0] defects_o
);

    // layer u sits at bits u*plane_count and up, same as the vertex index
    logic [decoder_pkg::grid_u-1:0][decoder_pkg::plane_count-1:0] layers;
    logic [decoder_pkg::plane_count-1:0] meas_q; // sampled with the stage

    always_ff @(posedge clk) begin
        if (reset) begin
            strobes_o <= '0;
        end else begin
            strobes_o.load <= (stage_i == decoder_pkg::stage_load);
            strobes_o.grow <= (stage_i == decoder_pkg::stage_grow);
            strobes_o.merge <= (stage_i == decoder_pkg::stage_merge);
        end
    end

    // keeps the data aligned with its strobe
    always_ff @(posedge clk) begin
        meas_q <= measurements_i;
    end

    // new round enters on top, older rounds move down one layer
    always_ff @(posedge clk) begin
        if (reset) begin
            layers <= '0;
        end else if (strobes_o.load) begin
            layers <= {meas_q, layers[decoder_pkg::grid_u-1:1]};
        end
    end

    assign defects_o = layers;

endmodule

//--- vertex_unit.sv
`timescale 1ns/1ps

module vertex_unit #(
    parameter decoder_pkg::vertex_addr_t vertex_id = '0
) (
    input  logic clk,
    input  logic reset,
    input  decoder_pkg::stage_strobes_t strobes_i,
    input  logic [decoder_pkg::neighbor_count-1:0] grown_i,
    input  decoder_pkg::vertex_state_t [decoder_pkg::neighbor_count-1:0] neighbor_state_i,
    input  logic boundary_grown_i,
    output decoder_pkg::vertex_state_t state_o,
    output logic changed_o
);

    decoder_pkg::vertex_state_t state_q;
    decoder_pkg::vertex_state_t merged;

    // one flooding step over all fully grown edges
    always_comb begin
        merged = state_q;
        for (int d = 0; d < decoder_pkg::neighbor_count; d++) begin
            if (grown_i[d]) begin
                if (neighbor_state_i[d].root < merged.root) begin
                    merged.root = neighbor_state_i[d].root;
                end
                merged.boundary = merged.boundary | neighbor_state_i[d].boundary;
            end
        end
        merged.boundary = merged.boundary | boundary_grown_i; // grown into the boundary itself
    end

    always_ff @(posedge clk) begin
        if (reset || strobes_i.load) begin
            state_q.root <= vertex_id; // every vertex starts as its own root
            state_q.boundary <= 1'b0;
        end else if (strobes_i.merge) begin
            state_q <= merged;
        end
    end

    assign state_o = state_q;

    // high in the merge cycle that updates the state
    assign changed_o = strobes_i.merge && (merged != state_q);

endmodule

//--- edge_unit.sv
`timescale 1ns/1ps

module edge_unit #(
    parameter bit single_ended = 1'b0
) (
    input  logic clk,
    input  logic reset,
    input  decoder_pkg::stage_strobes_t strobes_i,
    input  logic defect_a_i,
    input  logic defect_b_i,
    output logic fully_grown_o
);

    logic [decoder_pkg::growth_bits-1:0] count_q;
    logic [decoder_pkg::growth_bits-1:0] incr;
    logic [decoder_pkg::growth_bits:0] sum; // one spare bit for the overflow

    // each defect endpoint grows the edge by one step
    assign incr = single_ended ? {1'b0, defect_a_i}
                               : {1'b0, defect_a_i} + {1'b0, defect_b_i};
    assign sum = {1'b0, count_q} + {1'b0, incr};

    always_ff @(posedge clk) begin
        if (reset || strobes_i.load) begin
            count_q <= '0;
        end else if (strobes_i.grow) begin
            if (sum >= {1'b0, decoder_pkg::link_weight}) begin
                count_q <= decoder_pkg::link_weight; // saturate
            end else begin
                count_q <= sum[decoder_pkg::growth_bits-1:0];
            end
        end
    end

    assign fully_grown_o = (count_q == decoder_pkg::link_weight);

endmodule

//--- decoding_graph.sv
`timescale 1ns/1ps

module decoding_graph (
    input  logic clk,
    input  logic reset,
    input  decoder_pkg::stage_strobes_t strobes_i,
    input  logic [decoder_pkg::vertex_count-1:0] defects_i,
    output decoder_pkg::vertex_state_t [decoder_pkg::vertex_count-1:0] states_o,
    output logic [decoder_pkg::vertex_count-1:0] changed_o
);

    // edges towards south, east and up belong to the vertex they start from
    logic [decoder_pkg::vertex_count-1:0][decoder_pkg::neighbor_count/2-1:0] fwd_grown;
    logic [decoder_pkg::vertex_count-1:0] bnd_grown; // single ended edge at x = 0 or last row

    for (genvar v = 0; v < decoder_pkg::vertex_count; v++) begin : g_vertex
        logic [decoder_pkg::neighbor_count-1:0] grown;
        decoder_pkg::vertex_state_t [decoder_pkg::neighbor_count-1:0] nbr;

        for (genvar d = 0; d < decoder_pkg::neighbor_count; d++) begin : g_dir
            if (decoder_pkg::neighbor_of(v, d) < 0) begin : g_none
                assign grown[d] = 1'b0; // no neighbour, never grown
                assign nbr[d] = '0;
                if (d % 2 == 1) begin : g_tie
                    assign fwd_grown[v][d/2] = 1'b0;
                end
            end else if (d % 2 == 0) begin : g_back
                // edge is owned by the neighbour on the other side
                assign grown[d] = fwd_grown[decoder_pkg::neighbor_of(v, d)][d/2];
                assign nbr[d] = states_o[decoder_pkg::neighbor_of(v, d)];
            end else begin : g_fwd
                edge_unit #(
                    .single_ended(1'b0)
                ) u_edge (
                    .clk(clk),
                    .reset(reset),
                    .strobes_i(strobes_i),
                    .defect_a_i(defects_i[v]),
                    .defect_b_i(defects_i[decoder_pkg::neighbor_of(v, d)]),
                    .fully_grown_o(fwd_grown[v][d/2])
                );
                assign grown[d] = fwd_grown[v][d/2];
                assign nbr[d] = states_o[decoder_pkg::neighbor_of(v, d)];
            end
        end

        // north boundary above row 0, south boundary below the last row
        if ((v % decoder_pkg::plane_count) / decoder_pkg::grid_z == 0 ||
            (v % decoder_pkg::plane_count) / decoder_pkg::grid_z == decoder_pkg::grid_x - 1)
        begin : g_bnd
            edge_unit #(
                .single_ended(1'b1)
            ) u_bnd_edge (
                .clk(clk),
                .reset(reset),
                .strobes_i(strobes_i),
                .defect_a_i(defects_i[v]),
                .defect_b_i(1'b0),
                .fully_grown_o(bnd_grown[v])
            );
        end else begin : g_no_bnd
            assign bnd_grown[v] = 1'b0;
        end

        vertex_unit #(
            .vertex_id(decoder_pkg::vertex_addr(v))
        ) u_vertex (
            .clk(clk),
            .reset(reset),
            .strobes_i(strobes_i),
            .grown_i(grown),
            .neighbor_state_i(nbr),
            .boundary_grown_i(bnd_grown[v]),
            .state_o(states_o[v]),
            .changed_o(changed_o[v])
        );
    end

endmodule

//--- cluster_report.sv
`timescale 1ns/1ps

module cluster_report (
    input  logic clk,
    input  logic reset,
    input  decoder_pkg::vertex_state_t [decoder_pkg::vertex_count-1:0] states_i,
    input  logic [decoder_pkg::vertex_count-1:0] changed_i,
    output logic [decoder_pkg::vertex_count*decoder_pkg::addr_bits-1:0] roots_o,
    output logic [decoder_pkg::vertex_count-1:0] boundary_o,
    output logic busy_o
);

    // field i of roots_o holds the root of vertex i
    always_ff @(posedge clk) begin
        for (int i = 0; i < decoder_pkg::vertex_count; i++) begin
            roots_o[i*decoder_pkg::addr_bits +: decoder_pkg::addr_bits] <= states_i[i].root;
            boundary_o[i] <= states_i[i].boundary;
        end
    end

    // any vertex still moving keeps the merge busy
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_o <= 1'b0;
        end else begin
            busy_o <= |changed_i;
        end
    end

endmodule

//--- decoder_top.sv
`timescale 1ns/1ps

module decoder_top (
    input  logic clk,
    input  logic reset,
    input  decoder_pkg::stage_t stage_i,
    input  logic [decoder_pkg::plane_count-1:0] measurements_i,
    output logic [decoder_pkg::vertex_count*decoder_pkg::addr_bits-1:0] roots_o,
    output logic [decoder_pkg::vertex_count-1:0] boundary_o,
    output logic busy_o
);

    decoder_pkg::stage_strobes_t strobes;
    logic [decoder_pkg::vertex_count-1:0] defects;
    decoder_pkg::vertex_state_t [decoder_pkg::vertex_count-1:0] states;
    logic [decoder_pkg::vertex_count-1:0] changed;

    syndrome_loader u_loader (
        .clk(clk),
        .reset(reset),
        .stage_i(stage_i),
        .measurements_i(measurements_i),
        .strobes_o(strobes),
        .defects_o(defects)
    );

    decoding_graph u_graph (
        .clk(clk),
        .reset(reset),
        .strobes_i(strobes),
        .defects_i(defects),
        .states_o(states),
        .changed_o(changed)
    );

    cluster_report u_report (
        .clk(clk),
        .reset(reset),
        .states_i(states),
        .changed_i(changed),
        .roots_o(roots_o),
        .boundary_o(boundary_o),
        .busy_o(busy_o)
    );

endmodule

//--- tb_decoder_asserts.sv
`timescale 1ns/1ps

module tb_decoder_asserts (
    input  logic clk,
    input  logic reset,
    input  decoder_pkg::stage_t stage_i,
    input  logic [decoder_pkg::vertex_count*decoder_pkg::addr_bits-1:0] roots_i,
    input  logic [decoder_pkg::vertex_count-1:0] boundary_i,
    input  logic busy_i
);

    logic merge_seen; // a merge stage was driven since the last load

    always_ff @(posedge clk) begin
        if (reset || stage_i == decoder_pkg::stage_load) begin
            merge_seen <= 1'b0;
        end else if (stage_i == decoder_pkg::stage_merge) begin
            merge_seen <= 1'b1;
        end
    end

    // nothing can move before the first merge of a round
    busy_needs_merge: assert property (@(posedge clk) disable iff (reset)
        !merge_seen |-> !busy_i)
        else $error("busy high with no merge since the last load");

    // merge settles within the vertex count once the stage leaves merge
    busy_falls: assert property (@(posedge clk) disable iff (reset)
        ($past(stage_i) == decoder_pkg::stage_merge && stage_i != decoder_pkg::stage_merge)
        |-> ##[0:decoder_pkg::vertex_count+2] !busy_i)
        else $error("busy did not fall after the merge stage");

    outputs_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({roots_i, boundary_i, busy_i}))
        else $error("unknown value on a DUT output");

endmodule

//--- tb_decoder.sv
`timescale 1ns/1ps

module tb_decoder;

    localparam int merge_cycles = decoder_pkg::vertex_count + 3;

    logic clk;
    logic reset;
    decoder_pkg::stage_t stage_i;
    logic [decoder_pkg::plane_count-1:0] measurements_i;
    logic [decoder_pkg::vertex_count*decoder_pkg::addr_bits-1:0] roots_o;
    logic [decoder_pkg::vertex_count-1:0] boundary_o;
    logic busy_o;

    // one entry per vector line
    string names[$];
    logic [decoder_pkg::plane_count-1:0] meas_bottom[$];
    logic [decoder_pkg::plane_count-1:0] meas_top[$];
    int grow_steps[$];
    logic [decoder_pkg::vertex_count*decoder_pkg::addr_bits-1:0] exp_roots[$];
    logic [decoder_pkg::vertex_count-1:0] exp_boundary[$];

    int cycle_count;
    int cycle_limit;

    decoder_top u_dut (
        .clk(clk),
        .reset(reset),
        .stage_i(stage_i),
        .measurements_i(measurements_i),
        .roots_o(roots_o),
        .boundary_o(boundary_o),
        .busy_o(busy_o)
    );

    bind decoder_top tb_decoder_asserts u_asserts (
        .clk(clk),
        .reset(reset),
        .stage_i(stage_i),
        .roots_i(roots_o),
        .boundary_i(boundary_o),
        .busy_i(busy_o)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // counts through the lattice in numbering order, z fastest, then x, then u
    function automatic decoder_pkg::vertex_addr_t own_address(int v);
        decoder_pkg::vertex_addr_t a;
        a = '0;
        repeat (v) begin
            if (int'(a.z) < decoder_pkg::grid_z - 1) begin
                a.z = a.z + 1'b1;
            end else begin
                a.z = '0;
                if (int'(a.x) < decoder_pkg::grid_x - 1) begin
                    a.x = a.x + 1'b1;
                end else begin
                    a.x = '0; // next layer
                    a.u = a.u + 1'b1;
                end
            end
        end
        return a;
    endfunction

    task automatic check_roots(string name, int v, decoder_pkg::vertex_addr_t expected,
                               decoder_pkg::vertex_addr_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s root of vertex %0d expected %h actual %h",
                     name, v, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "root mismatch");
        end
    endtask

    task automatic check_boundary(string name, logic [decoder_pkg::vertex_count-1:0] expected,
                                  logic [decoder_pkg::vertex_count-1:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s boundary expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "boundary mismatch");
        end
    endtask

    task automatic check_busy(string name, logic expected, logic actual);
        if (expected !== actual) begin
            $display("MISMATCH %s busy expected %b actual %b", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "busy mismatch");
        end
    endtask

    task automatic read_vectors();
        int fd;
        int n;
        string line;
        string nm;
        logic [decoder_pkg::plane_count-1:0] m0;
        logic [decoder_pkg::plane_count-1:0] m1;
        int g;
        logic [decoder_pkg::vertex_count*decoder_pkg::addr_bits-1:0] r;
        logic [decoder_pkg::vertex_count-1:0] b;
        fd = $fopen("tb_decoder_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            $display("TEST FAILED");
            $fatal(1, "no vectors");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %d %h %h", nm, m0, m1, g, r, b);
                if (n == 6) begin
                    names.push_back(nm);
                    meas_bottom.push_back(m0);
                    meas_top.push_back(m1);
                    grow_steps.push_back(g);
                    exp_roots.push_back(r);
                    exp_boundary.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    // drive a stage a little after the rising edge
    task automatic drive(decoder_pkg::stage_t s, logic [decoder_pkg::plane_count-1:0] m);
        @(posedge clk);
        #2;
        stage_i = s;
        measurements_i = m;
    endtask

    task automatic run_test(int t);
        decoder_pkg::vertex_addr_t exp_a;
        decoder_pkg::vertex_addr_t act_a;
        logic busy_seen;
        logic moved; // some vertex ends away from its state after load
        busy_seen = 1'b0;
        moved = |exp_boundary[t];
        drive(decoder_pkg::stage_load, meas_bottom[t]); // older round first
        drive(decoder_pkg::stage_load, meas_top[t]);
        repeat (grow_steps[t]) drive(decoder_pkg::stage_grow, '0);
        repeat (merge_cycles) begin
            drive(decoder_pkg::stage_merge, '0);
            busy_seen = busy_seen | busy_o;
        end
        repeat (2) drive(decoder_pkg::stage_idle, '0); // strobe and report latency
        while (busy_o) begin
            drive(decoder_pkg::stage_idle, '0);
        end
        @(negedge clk);
        for (int v = 0; v < decoder_pkg::vertex_count; v++) begin
            exp_a = exp_roots[t][v*decoder_pkg::addr_bits +: decoder_pkg::addr_bits];
            act_a = roots_o[v*decoder_pkg::addr_bits +: decoder_pkg::addr_bits];
            check_roots(names[t], v, exp_a, act_a);
            moved = moved | (exp_a != own_address(v));
        end
        check_boundary(names[t], exp_boundary[t], boundary_o);
        check_busy(names[t], moved, busy_seen); // busy rises only when a state moves
    endtask

    initial begin
        reset = 1'b1;
        stage_i = decoder_pkg::stage_idle;
        measurements_i = '0;
        cycle_count = 0;
        cycle_limit = 0;

        read_vectors();
        if (names.size() == 0) begin
            $display("the vector file holds no tests");
            $display("TEST FAILED");
            $fatal(1, "empty vectors");
        end
        cycle_limit = 10; // reset and the first check
        foreach (grow_steps[i]) cycle_limit += grow_steps[i] + decoder_pkg::vertex_count + 10;

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        // before any load every vertex is its own root
        @(negedge clk);
        for (int v = 0; v < decoder_pkg::vertex_count; v++) begin
            check_roots("after_reset", v, own_address(v),
                        roots_o[v*decoder_pkg::addr_bits +: decoder_pkg::addr_bits]);
        end
        check_boundary("after_reset", '0, boundary_o);
        check_busy("after_reset", 1'b0, busy_o);

        for (int t = 0; t < names.size(); t++) begin
            run_test(t);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- tb_decoder_vectors.txt
# name  bottom_meas top_meas grow_steps expected_roots(field v = 5 bits at 5*v) boundary_mask
# measurement bit x*3+z per layer, all values hex except grow_steps
empty 000 000 3 F779ACE2D5A4A307358A4A0C520820 000000
pair 030 040 1 F779ACE2D5A4A307358A4A0A520820 000000
chain 010 080 2 F0781086C1A4A307358A0A02108820 000000
north 002 840 2 7390E422D5448107358A4A0C020000 D02817
pair_again 030 040 1 F779ACE2D5A4A307358A4A0A520820 000000
empty_again 000 000 0 F779ACE2D5A4A307358A4A0C520820 000000

//--- src.f
decoder_pkg.sv
syndrome_loader.sv
vertex_unit.sv
edge_unit.sv
decoding_graph.sv
cluster_report.sv
decoder_top.sv
tb_decoder_asserts.sv
tb_decoder.sv
